//--- project.f
common/lsu_pkg.sv
hdl/lsu_agen.sv
store_queue/sq_forward.sv
store_queue/store_queue.sv
hdl/load_align.sv
hdl/lsu_top.sv
tests/tb_lsu.sv

//--- run.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_lsu -o tb_lsu_sim \
    && ./obj_dir/tb_lsu_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0

//--- tests/tb_lsu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_lsu;

    localparam int NR_SQ = 4;
    localparam int N_REQ = 26;
    // Every request gets 20 cycles, plus the reset time
    localparam int WATCHDOG_NS = (N_REQ * 20 + 16) * 10;

    logic                clk = 1'b0;
    logic                rstn;
    lsu_pkg::lsu_req_t   req_i;
    logic                req_valid_i;
    logic                req_ready_o;
    lsu_pkg::lsu_resp_t  resp_o;
    logic                resp_valid_o;
    lsu_pkg::st_done_t   st_done_o;
    logic                retire_st_i;
    logic                squash_i;
    lsu_pkg::dc_write_t  dc_wr_o;
    logic                dc_wvalid_o;
    logic                dc_wready_i;
    lsu_pkg::xlen_t      dc_raddr_o;
    logic                dc_rvalid_o;
    logic                dc_rready_i;
    lsu_pkg::xlen_t      dc_rdata_i;
    logic                dc_rdata_valid_i;

    // Cache contents, one byte per address
    logic [7:0]          mem [0:255];
    // Expected stores in program order, drained ones stay at the front
    lsu_pkg::dc_write_t  ref_q [$];
    lsu_pkg::lsu_resp_t  exp_resp [0:63];
    lsu_pkg::inst_id_t   exp_done [0:63];
    int                  n_loads;
    int                  n_stores;
    int                  n_committed;
    int                  n_resp;
    int                  n_done;
    int                  n_drained;
    int                  err_val;
    int                  err_flow;
    int                  err_main;
    string               test_name;
    logic [7:0]          next_id;
    logic [15:0]         lfsr_main;
    logic [15:0]         lfsr_cache;
    logic                rd_acc;
    lsu_pkg::xlen_t      rd_addr;
    int                  rd_cnt;

    always #5 clk = ~clk;

    lsu_top #(
        .NR_SQ_ENTRIES (NR_SQ)
    ) UUT (
        .clk              (clk),
        .rstn             (rstn),
        .req_i            (req_i),
        .req_valid_i      (req_valid_i),
        .req_ready_o      (req_ready_o),
        .resp_o           (resp_o),
        .resp_valid_o     (resp_valid_o),
        .st_done_o        (st_done_o),
        .retire_st_i      (retire_st_i),
        .squash_i         (squash_i),
        .dc_wr_o          (dc_wr_o),
        .dc_wvalid_o      (dc_wvalid_o),
        .dc_wready_i      (dc_wready_i),
        .dc_raddr_o       (dc_raddr_o),
        .dc_rvalid_o      (dc_rvalid_o),
        .dc_rready_i      (dc_rready_i),
        .dc_rdata_i       (dc_rdata_i),
        .dc_rdata_valid_i (dc_rdata_valid_i)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [15:0] take_bits(input int n, inout logic [15:0] s);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            s = lfsr_next(s);
            v[i] = s[0];
        end
        return v;
    endfunction

    function automatic logic [7:0] fill_byte(input logic [7:0] a);
        return ((a * 8'd29) ^ {a[3:0], a[7:4]}) + 8'h5B;
    endfunction

    function automatic logic [7:0] size_mask(input lsu_pkg::size_e sz, input logic [2:0] off);
        case (sz)
            lsu_pkg::SIZE_B: return 8'h01 << off;
            lsu_pkg::SIZE_H: return 8'h03 << off;
            lsu_pkg::SIZE_W: return 8'h0F << off;
            default:         return 8'hFF;
        endcase
    endfunction

    function automatic lsu_pkg::lsu_req_t make_req(input lsu_pkg::lsu_op_e op,
                                                   input lsu_pkg::size_e sz,
                                                   input lsu_pkg::xlen_t addr,
                                                   input lsu_pkg::xlen_t data);
        lsu_pkg::lsu_req_t r;
        r.op    = op;
        r.size  = sz;
        r.id    = next_id;
        r.prd   = next_id[6:0] ^ 7'h2A;
        r.base  = addr - 64'h18;
        r.imm   = 64'h18;
        r.wdata = data;
        next_id = next_id + 8'd1;
        return r;
    endfunction

    // Cache write that a store must produce
    function automatic lsu_pkg::dc_write_t exp_write(input lsu_pkg::lsu_req_t r);
        lsu_pkg::dc_write_t w;
        lsu_pkg::xlen_t     addr;
        addr   = r.base + r.imm;
        w.addr = addr;
        w.mask = size_mask(r.size, addr[2:0]);
        w.data = (r.size == lsu_pkg::SIZE_D) ? r.wdata : (r.wdata << {addr[2:0], 3'b000});
        return w;
    endfunction

    // Load value from memory, with bytes of the youngest queued store taking priority
    function automatic lsu_pkg::lsu_resp_t ref_load(input lsu_pkg::lsu_req_t r);
        lsu_pkg::xlen_t     addr;
        lsu_pkg::xlen_t     word;
        lsu_pkg::xlen_t     val;
        logic [7:0]         lmask;
        logic               found;
        logic               sext;
        lsu_pkg::lsu_resp_t rsp;
        addr  = r.base + r.imm;
        lmask = size_mask(r.size, addr[2:0]);
        sext  = (r.op == lsu_pkg::OP_LD);
        for (int b = 0; b < 8; b++) begin
            word[8*b +: 8] = mem[{addr[7:3], 3'(b)}];
            found = 1'b0;
            for (int j = ref_q.size() - 1; j >= n_drained; j--) begin
                if (!found && lmask[b] && ref_q[j].mask[b] &&
                    ref_q[j].addr[63:3] == addr[63:3]) begin
                    word[8*b +: 8] = ref_q[j].data[8*b +: 8];
                    found = 1'b1;
                end
            end
        end
        val = word >> {addr[2:0], 3'b000};
        case (r.size)
            lsu_pkg::SIZE_B: val = {{56{sext & val[7]}}, val[7:0]};
            lsu_pkg::SIZE_H: val = {{48{sext & val[15]}}, val[15:0]};
            lsu_pkg::SIZE_W: val = {{32{sext & val[31]}}, val[31:0]};
            default:         val = val;
        endcase
        rsp.id    = r.id;
        rsp.prd   = r.prd;
        rsp.rdval = val;
        return rsp;
    endfunction

    task automatic check_resp(input string name, input lsu_pkg::lsu_resp_t exp,
                              input lsu_pkg::lsu_resp_t act);
        if (exp !== act) begin
            err_val++;
            $display("Error %s: expected id=%h prd=%h rdval=%h, actual id=%h prd=%h rdval=%h",
                     name, exp.id, exp.prd, exp.rdval, act.id, act.prd, act.rdval);
        end
    endtask

    task automatic check_write(input string name, input lsu_pkg::dc_write_t exp,
                               input lsu_pkg::dc_write_t act);
        if (exp !== act) begin
            err_val++;
            $display("Error %s: expected addr=%h data=%h mask=%h, actual addr=%h data=%h mask=%h",
                     name, exp.addr, exp.data, exp.mask, act.addr, act.data, act.mask);
        end
    endtask

    task automatic check_done(input string name, input lsu_pkg::st_done_t exp,
                              input lsu_pkg::st_done_t act);
        if (exp !== act) begin
            err_val++;
            $display("Error %s: expected store done id=%h, actual valid=%b id=%h",
                     name, exp.id, act.valid, act.id);
        end
    endtask

    task automatic check_addr(input string name, input lsu_pkg::xlen_t exp,
                              input lsu_pkg::xlen_t act);
        if (exp !== act) begin
            err_val++;
            $display("Error %s: expected read addr=%h, actual read addr=%h", name, exp, act);
        end
    endtask

    // Hold the request until the DUT takes it
    task automatic issue(input lsu_pkg::lsu_req_t r);
        @(negedge clk);
        req_i       = r;
        req_valid_i = 1'b1;
        @(posedge clk);
        while (!req_ready_o) begin
            @(posedge clk);
        end
        if (r.op != lsu_pkg::OP_ST && !dc_rvalid_o) begin
            err_main++;
            $display("%s: load accepted without a cache read request", test_name);
        end
        if (r.op != lsu_pkg::OP_ST) begin
            check_addr(test_name, r.base + r.imm, dc_raddr_o);
        end
        @(negedge clk);
        req_valid_i = 1'b0;
    endtask

    task automatic do_store(input lsu_pkg::size_e sz, input lsu_pkg::xlen_t addr,
                            input lsu_pkg::xlen_t data);
        lsu_pkg::lsu_req_t r;
        r = make_req(lsu_pkg::OP_ST, sz, addr, data);
        exp_done[n_stores] = r.id;
        n_stores++;
        ref_q.push_back(exp_write(r));
        issue(r);
    endtask

    task automatic do_load(input lsu_pkg::lsu_op_e op, input lsu_pkg::size_e sz,
                           input lsu_pkg::xlen_t addr);
        lsu_pkg::lsu_req_t r;
        r = make_req(op, sz, addr, '0);
        exp_resp[n_loads] = ref_load(r);
        n_loads++;
        issue(r);
        while (n_resp != n_loads) begin
            @(posedge clk);
        end
    endtask

    task automatic retire;
        @(negedge clk);
        retire_st_i = 1'b1;
        @(posedge clk);
        n_committed++;
        @(negedge clk);
        retire_st_i = 1'b0;
    endtask

    task automatic squash_stores;
        @(negedge clk);
        squash_i = 1'b1;
        @(posedge clk);
        while (ref_q.size() > n_committed) begin
            void'(ref_q.pop_back());
        end
        @(negedge clk);
        squash_i = 1'b0;
    endtask

    task automatic wait_drained;
        while (n_drained != ref_q.size()) begin
            @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        rd_acc  <= rstn && dc_rvalid_o;
        rd_addr <= dc_raddr_o;
    end

    // Cache read side, 1 to 3 cycles of latency
    initial begin : cache_model
        logic [15:0] rb;
        dc_rdata_i       = '0;
        dc_rdata_valid_i = 1'b0;
        rd_cnt           = 0;
        lfsr_cache       = 16'd5698;
        forever begin
            @(negedge clk);
            dc_rdata_valid_i = 1'b0;
            if (rd_acc) begin
                rb     = take_bits(2, lfsr_cache);
                rd_cnt = 1 + int'(rb[1:0]) % 3;
            end
            if (rd_cnt != 0) begin
                rd_cnt--;
                if (rd_cnt == 0) begin
                    for (int b = 0; b < 8; b++) begin
                        dc_rdata_i[8*b +: 8] = mem[{rd_addr[7:3], 3'(b)}];
                    end
                    dc_rdata_valid_i = 1'b1;
                end
            end
        end
    end

    // Compares responses, completions and cache writes; applies writes to memory
    initial begin : compare
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_byte(8'(i));
        end
        n_resp    = 0;
        n_done    = 0;
        n_drained = 0;
        err_val   = 0;
        err_flow  = 0;
        forever begin
            @(posedge clk);
            if (rstn) begin
                if (resp_valid_o) begin
                    if (n_resp == n_loads) begin
                        err_flow++;
                        $display("%s: load response without an outstanding load", test_name);
                    end else begin
                        check_resp(test_name, exp_resp[n_resp], resp_o);
                        n_resp++;
                    end
                end
                if (st_done_o.valid) begin
                    if (n_done == n_stores) begin
                        err_flow++;
                        $display("%s: store completion without a store", test_name);
                    end else begin
                        check_done(test_name, '{valid: 1'b1, id: exp_done[n_done]}, st_done_o);
                        n_done++;
                    end
                end
                if (dc_wvalid_o) begin
                    if (n_drained >= n_committed) begin
                        err_flow++;
                        $display("%s: cache write from a store that was never committed",
                                 test_name);
                    end else begin
                        check_write(test_name, ref_q[n_drained], dc_wr_o);
                        n_drained++;
                    end
                    for (int b = 0; b < 8; b++) begin
                        if (dc_wr_o.mask[b]) begin
                            mem[{dc_wr_o.addr[7:3], 3'(b)}] = dc_wr_o.data[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("TEST FAIL");
        $finish;
    end

    initial begin : main
        logic [15:0]       rb;
        logic [7:0]        a;
        lsu_pkg::size_e    sz;
        rstn        = 1'b0;
        req_i       = '0;
        req_valid_i = 1'b0;
        retire_st_i = 1'b0;
        squash_i    = 1'b0;
        dc_wready_i = 1'b1;
        dc_rready_i = 1'b1;
        next_id     = 8'd0;
        lfsr_main   = 16'd5698;
        n_loads     = 0;
        n_stores    = 0;
        n_committed = 0;
        err_main    = 0;
        test_name   = "reset";
        repeat (16) @(negedge clk);
        rstn = 1'b1;
        @(posedge clk);
        if (dc_wvalid_o || resp_valid_o || st_done_o.valid || dc_rvalid_o || !req_ready_o) begin
            err_main++;
            $display("Outputs are not idle after reset");
        end

        test_name = "store_sizes";
        do_store(lsu_pkg::SIZE_B, 64'h11, 64'hA5);
        do_store(lsu_pkg::SIZE_H, 64'h22, 64'hBEEF);
        do_store(lsu_pkg::SIZE_W, 64'h34, 64'h8765_4321);
        do_store(lsu_pkg::SIZE_D, 64'h48, 64'hF0E1_D2C3_B4A5_9687);
        repeat (4) retire();
        wait_drained();
        do_load(lsu_pkg::OP_LD, lsu_pkg::SIZE_W, 64'h34);
        do_load(lsu_pkg::OP_LDU, lsu_pkg::SIZE_H, 64'h22);

        test_name = "plain_loads";
        for (int k = 0; k < 8; k++) begin
            rb = take_bits(7, lfsr_main);
            a  = 8'h80 | rb[7:0];
            rb = take_bits(2, lfsr_main);
            sz = lsu_pkg::size_e'(rb[1:0]);
            a  = a & (8'hFF << sz);
            rb = take_bits(1, lfsr_main);
            do_load(rb[0] ? lsu_pkg::OP_LDU : lsu_pkg::OP_LD, sz, {56'h0, a});
        end

        test_name = "forward";
        @(negedge clk);
        dc_wready_i = 1'b0;
        do_store(lsu_pkg::SIZE_D, 64'h90, 64'h1122_3344_5566_7788);
        do_store(lsu_pkg::SIZE_W, 64'h90, 64'hCAFE_F00D);
        do_load(lsu_pkg::OP_LD, lsu_pkg::SIZE_D, 64'h90);
        do_store(lsu_pkg::SIZE_H, 64'hA2, 64'hBEEF);
        do_load(lsu_pkg::OP_LD, lsu_pkg::SIZE_W, 64'hA0);

        test_name = "squash";
        repeat (3) retire();
        do_store(lsu_pkg::SIZE_D, 64'hB0, 64'h0BAD_0BAD_0BAD_0BAD);
        squash_stores();
        do_load(lsu_pkg::OP_LDU, lsu_pkg::SIZE_D, 64'hB0);
        @(negedge clk);
        dc_wready_i = 1'b1;
        wait_drained();

        test_name = "backpressure";
        @(negedge clk);
        dc_wready_i = 1'b0;
        for (int k = 0; k < NR_SQ; k++) begin
            rb = take_bits(16, lfsr_main);
            do_store(lsu_pkg::SIZE_D, 64'hC0 + 64'(8 * k), {4{rb}});
        end
        repeat (NR_SQ) retire();
        if (req_ready_o !== 1'b0) begin
            err_main++;
            $display("Request ready stayed high with a full store queue");
        end
        dc_wready_i = 1'b1;
        @(posedge clk);
        while (!req_ready_o) begin
            @(posedge clk);
        end
        wait_drained();
        @(negedge clk);
        dc_rready_i = 1'b0;
        @(posedge clk);
        if (req_ready_o !== 1'b0) begin
            err_main++;
            $display("Request ready stayed high while the cache read port was busy");
        end
        @(negedge clk);
        dc_rready_i = 1'b1;
        do_load(lsu_pkg::OP_LD, lsu_pkg::SIZE_D, 64'hC8);

        repeat (4) @(posedge clk);
        if (n_resp != n_loads || n_done != n_stores) begin
            err_main++;
            $display("Load responses or store completions are missing at the end");
        end
        $display("Errors: %0d wrong values, %0d other failures", err_val, err_flow + err_main);
        if (err_val + err_flow + err_main == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/lsu_top.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_top #(
    parameter int NR_SQ_ENTRIES = 4
) (
    input  wire logic                clk,
    input  wire logic                rstn,
    // Core request and results
    input  wire lsu_pkg::lsu_req_t   req_i,
    input  wire logic                req_valid_i,
    output logic                     req_ready_o,
    output lsu_pkg::lsu_resp_t       resp_o,
    output logic                     resp_valid_o,
    output lsu_pkg::st_done_t        st_done_o,
    input  wire logic                retire_st_i,
    input  wire logic                squash_i,
    // Cache write port
    output lsu_pkg::dc_write_t       dc_wr_o,
    output logic                     dc_wvalid_o,
    input  wire logic                dc_wready_i,
    // Cache read port
    output lsu_pkg::xlen_t           dc_raddr_o,
    output logic                     dc_rvalid_o,
    input  wire logic                dc_rready_i,
    input  wire lsu_pkg::xlen_t      dc_rdata_i,
    input  wire logic                dc_rdata_valid_i
);

    lsu_pkg::sq_entry_t push_entry;
    lsu_pkg::load_ctx_t ld_ctx;
    lsu_pkg::fwd_t      fwd;
    logic               push;
    logic               ld;
    logic [7:0]         ld_mask;
    logic               sq_free;

    // Both a queue slot and the read port must be free
    assign req_ready_o = sq_free && dc_rready_i;
    assign dc_rvalid_o = ld;

    lsu_agen u_agen (
        .req_i        (req_i),
        .req_valid_i  (req_valid_i),
        .ready_i      (req_ready_o),
        .push_entry_o (push_entry),
        .push_o       (push),
        .ld_o         (ld),
        .ld_addr_o    (dc_raddr_o),
        .ld_mask_o    (ld_mask),
        .ld_ctx_o     (ld_ctx),
        .st_done_o    (st_done_o)
    );

    store_queue #(
        .NR_SQ_ENTRIES (NR_SQ_ENTRIES)
    ) u_store_queue (
        .clk          (clk),
        .rstn         (rstn),
        .push_i       (push),
        .push_entry_i (push_entry),
        .commit_i     (retire_st_i),
        .squash_i     (squash_i),
        .wready_i     (dc_wready_i),
        .ld_i         (ld),
        .ld_addr_i    (dc_raddr_o),
        .ld_mask_i    (ld_mask),
        .fwd_o        (fwd),
        .free_o       (sq_free),
        .wr_o         (dc_wr_o),
        .wvalid_o     (dc_wvalid_o)
    );

    load_align u_load_align (
        .clk           (clk),
        .ld_i          (ld),
        .ctx_i         (ld_ctx),
        .fwd_i         (fwd),
        .rdata_i       (dc_rdata_i),
        .rdata_valid_i (dc_rdata_valid_i),
        .resp_o        (resp_o),
        .resp_valid_o  (resp_valid_o)
    );

endmodule

`default_nettype wire

//--- hdl/load_align.sv
`timescale 1ns/10ps
`default_nettype none

module load_align (
    input  wire logic                clk,
    input  wire logic                ld_i,
    input  wire lsu_pkg::load_ctx_t  ctx_i,
    input  wire lsu_pkg::fwd_t       fwd_i,
    input  wire lsu_pkg::xlen_t      rdata_i,
    input  wire logic                rdata_valid_i,
    output lsu_pkg::lsu_resp_t       resp_o,
    output logic                     resp_valid_o
);

    lsu_pkg::load_ctx_t ctx_d, ctx_q;
    lsu_pkg::xlen_t     merged;
    lsu_pkg::xlen_t     shifted;
    lsu_pkg::xlen_t     extended;

    always_comb begin
        ctx_d     = ctx_i;
        ctx_d.fwd = fwd_i;
    end

    // Single outstanding load, so one wait register is enough
    always_ff @(posedge clk) begin
        if (ld_i) begin
            ctx_q <= ctx_d;
        end
    end

    // Forwarded bytes win over the cache
    always_comb begin
        for (int b = 0; b < 8; b++) begin
            merged[8*b +: 8] = ctx_q.fwd.mask[b] ? ctx_q.fwd.data[8*b +: 8]
                                                 : rdata_i[8*b +: 8];
        end
    end

    assign shifted = merged >> (8 * ctx_q.offset);

    always_comb begin
        case (ctx_q.size)
            lsu_pkg::SIZE_B: extended = {{56{ctx_q.sext & shifted[7]}}, shifted[7:0]};
            lsu_pkg::SIZE_H: extended = {{48{ctx_q.sext & shifted[15]}}, shifted[15:0]};
            lsu_pkg::SIZE_W: extended = {{32{ctx_q.sext & shifted[31]}}, shifted[31:0]};
            default:         extended = shifted;
        endcase
    end

    assign resp_o.id     = ctx_q.id;
    assign resp_o.prd    = ctx_q.prd;
    assign resp_o.rdval  = extended;
    assign resp_valid_o  = rdata_valid_i;

endmodule

`default_nettype wire

//--- store_queue/store_queue.sv
`timescale 1ns/10ps
`default_nettype none

module store_queue #(
    parameter int NR_SQ_ENTRIES = 4
) (
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire logic                push_i,
    input  wire lsu_pkg::sq_entry_t  push_entry_i,
    input  wire logic                commit_i,
    input  wire logic                squash_i,
    input  wire logic                wready_i,
    input  wire logic                ld_i,
    input  wire lsu_pkg::xlen_t      ld_addr_i,
    input  wire logic [7:0]          ld_mask_i,
    output lsu_pkg::fwd_t            fwd_o,
    output logic                     free_o,
    output lsu_pkg::dc_write_t       wr_o,
    output logic                     wvalid_o
);

    localparam int PTR_W = $clog2(NR_SQ_ENTRIES);
    typedef logic [PTR_W-1:0] ptr_t;

    lsu_pkg::sq_entry_t [NR_SQ_ENTRIES-1:0] sq_q, sq_d;
    ptr_t issue_q, issue_d;
    ptr_t commit_q, commit_d;
    ptr_t pop_q, pop_d;
    // Wraps to zero when every entry is speculative, which is still the right rewind
    ptr_t spec_cnt;
    lsu_pkg::sq_entry_t head;

    assign head     = sq_q[pop_q];
    assign wvalid_o = head.valid && head.committed && wready_i;
    assign wr_o     = '{addr: head.paddr, data: head.fdata, mask: head.fmask};
    assign free_o   = !sq_q[issue_q].valid;

    always_comb begin
        sq_d     = sq_q;
        issue_d  = issue_q;
        commit_d = commit_q;
        pop_d    = pop_q;
        spec_cnt = '0;

        if (commit_i) begin
            sq_d[commit_q].committed = 1'b1;
            commit_d = commit_q + ptr_t'(1);
        end

        if (wvalid_o) begin
            sq_d[pop_q].valid     = 1'b0;
            sq_d[pop_q].committed = 1'b0;
            pop_d = pop_q + ptr_t'(1);
        end

        // Squash sees the queue after this cycle's commit and drain
        if (squash_i) begin
            for (int i = 0; i < NR_SQ_ENTRIES; i++) begin
                if (sq_d[i].valid && !sq_d[i].committed) begin
                    sq_d[i].valid = 1'b0;
                    spec_cnt = spec_cnt + ptr_t'(1);
                end
            end
            issue_d = issue_q - spec_cnt;
        end else if (push_i) begin
            sq_d[issue_q] = push_entry_i;
            issue_d = issue_q + ptr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            issue_q  <= '0;
            commit_q <= '0;
            pop_q    <= '0;
            for (int i = 0; i < NR_SQ_ENTRIES; i++) begin
                sq_q[i].valid     <= 1'b0;
                sq_q[i].committed <= 1'b0;
            end
        end else begin
            sq_q     <= sq_d;
            issue_q  <= issue_d;
            commit_q <= commit_d;
            pop_q    <= pop_d;
        end
    end

    sq_forward #(
        .NR_SQ_ENTRIES (NR_SQ_ENTRIES)
    ) u_sq_forward (
        .sq_i       (sq_q),
        .issue_id_i (issue_q),
        .ld_i       (ld_i),
        .ld_addr_i  (ld_addr_i),
        .ld_mask_i  (ld_mask_i),
        .fwd_o      (fwd_o)
    );

endmodule

`default_nettype wire

//--- store_queue/sq_forward.sv
`timescale 1ns/10ps
`default_nettype none

module sq_forward #(
    parameter int NR_SQ_ENTRIES = 4
) (
    input  wire lsu_pkg::sq_entry_t [NR_SQ_ENTRIES-1:0] sq_i,
    input  wire logic [$clog2(NR_SQ_ENTRIES)-1:0]       issue_id_i,
    input  wire logic                                   ld_i,
    input  wire lsu_pkg::xlen_t                         ld_addr_i,
    input  wire logic [7:0]                             ld_mask_i,
    output lsu_pkg::fwd_t                               fwd_o
);

    localparam int PTR_W = $clog2(NR_SQ_ENTRIES);
    localparam int TAG_LO = 3;
    typedef logic [PTR_W-1:0] ptr_t;

    // Index 0 is the youngest entry, index NR_SQ_ENTRIES-1 the oldest
    lsu_pkg::sq_entry_t [NR_SQ_ENTRIES-1:0] sq_ord;
    logic [NR_SQ_ENTRIES-1:0] match;
    logic [7:0]               new_bytes;
    logic [7:0]               fw_mask;
    lsu_pkg::xlen_t           fw_data;

    always_comb begin
        for (int i = 0; i < NR_SQ_ENTRIES; i++) begin
            sq_ord[i] = sq_i[issue_id_i - ptr_t'(i + 1)];
        end
    end

    // Same double word, valid entry
    always_comb begin
        for (int i = 0; i < NR_SQ_ENTRIES; i++) begin
            match[i] = ld_i && sq_ord[i].valid &&
                       (sq_ord[i].paddr[lsu_pkg::XLEN-1:TAG_LO] ==
                        ld_addr_i[lsu_pkg::XLEN-1:TAG_LO]);
        end
    end

    // A byte claimed by a younger store is never overwritten by an older one
    always_comb begin
        fw_mask   = '0;
        fw_data   = '0;
        new_bytes = '0;
        for (int i = 0; i < NR_SQ_ENTRIES; i++) begin
            if (match[i]) begin
                new_bytes = sq_ord[i].fmask & ld_mask_i & ~fw_mask;
                for (int b = 0; b < 8; b++) begin
                    if (new_bytes[b]) begin
                        fw_data[8*b +: 8] = sq_ord[i].fdata[8*b +: 8];
                    end
                end
                fw_mask = fw_mask | new_bytes;
            end
        end
    end

    assign fwd_o.mask = fw_mask;
    assign fwd_o.data = fw_data;

endmodule

`default_nettype wire

//--- hdl/lsu_agen.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_agen (
    input  wire lsu_pkg::lsu_req_t   req_i,
    input  wire logic                req_valid_i,
    input  wire logic                ready_i,
    output lsu_pkg::sq_entry_t       push_entry_o,
    output logic                     push_o,
    output logic                     ld_o,
    output lsu_pkg::xlen_t           ld_addr_o,
    output logic [7:0]               ld_mask_o,
    output lsu_pkg::load_ctx_t       ld_ctx_o,
    output lsu_pkg::st_done_t        st_done_o
);

    lsu_pkg::xlen_t addr;
    lsu_pkg::xlen_t st_data;
    logic [2:0]     bo;
    logic [7:0]     mask;
    logic           is_store;
    logic           is_load;
    logic           accept;

    assign addr     = req_i.base + req_i.imm;
    assign bo       = addr[2:0];
    assign is_store = (req_i.op == lsu_pkg::OP_ST);
    assign is_load  = (req_i.op == lsu_pkg::OP_LD) || (req_i.op == lsu_pkg::OP_LDU);
    assign accept   = req_valid_i && ready_i;

    // Byte lanes touched by the access, shared by loads and stores
    always_comb begin
        case (req_i.size)
            lsu_pkg::SIZE_B: mask = 8'b0000_0001 << bo;
            lsu_pkg::SIZE_H: mask = 8'b0000_0011 << bo;
            lsu_pkg::SIZE_W: mask = 8'b0000_1111 << bo;
            default:         mask = 8'hFF;
        endcase
    end

    // Double words go out as they are
    assign st_data = (req_i.size == lsu_pkg::SIZE_D) ? req_i.wdata
                                                     : (req_i.wdata << (8 * bo));

    assign push_o = accept && is_store;
    assign ld_o   = accept && is_load;

    assign push_entry_o.id        = req_i.id;
    assign push_entry_o.paddr     = addr;
    assign push_entry_o.fmask     = mask;
    assign push_entry_o.fdata     = st_data;
    assign push_entry_o.valid     = 1'b1;
    assign push_entry_o.committed = 1'b0;

    assign ld_addr_o = addr;
    assign ld_mask_o = mask;

    assign ld_ctx_o.id     = req_i.id;
    assign ld_ctx_o.prd    = req_i.prd;
    assign ld_ctx_o.offset = bo;
    assign ld_ctx_o.size   = req_i.size;
    assign ld_ctx_o.sext   = (req_i.op == lsu_pkg::OP_LD);
    // Filled in from the queue search by load_align
    assign ld_ctx_o.fwd    = '0;

    // Stores complete as soon as the address is known
    assign st_done_o.valid = push_o;
    assign st_done_o.id    = req_i.id;

endmodule

`default_nettype wire

//--- common/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;

    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } size_e;

    // OP_LD sign-extends, OP_LDU zero-extends
    typedef enum logic [1:0] {
        OP_LD  = 2'd0,
        OP_LDU = 2'd1,
        OP_ST  = 2'd2
    } lsu_op_e;

    typedef logic [7:0] inst_id_t;
    typedef logic [6:0] preg_t;

    typedef struct packed {
        lsu_op_e  op;
        size_e    size;
        inst_id_t id;
        preg_t    prd;
        xlen_t    base;
        xlen_t    imm;
        xlen_t    wdata;
    } lsu_req_t;

    // Store data and mask are already placed at their byte lanes
    typedef struct packed {
        inst_id_t   id;
        xlen_t      paddr;
        logic [7:0] fmask;
        xlen_t      fdata;
        logic       valid;
        logic       committed;
    } sq_entry_t;

    typedef struct packed {
        logic [7:0] mask;
        xlen_t      data;
    } fwd_t;

    typedef struct packed {
        inst_id_t   id;
        preg_t      prd;
        logic [2:0] offset;
        size_e      size;
        logic       sext;
        fwd_t       fwd;
    } load_ctx_t;

    typedef struct packed {
        inst_id_t id;
        preg_t    prd;
        xlen_t    rdval;
    } lsu_resp_t;

    typedef struct packed {
        logic     valid;
        inst_id_t id;
    } st_done_t;

    typedef struct packed {
        xlen_t      addr;
        xlen_t      data;
        logic [7:0] mask;
    } dc_write_t;

endpackage

`default_nettype wire
